// ==== all.f ====
rv_decode_pkg.sv
imm_gen.sv
ctrl_decode.sv
decode_stage.sv
rv_decoder.sv
tb_rv_decoder.sv

// ==== ctrl_decode.sv ====
`timescale 1ns/1ps

module ctrl_decode
   import rv_decode_pkg::*;
(
   input  logic [xlen-1:0]          i_instr,
   output logic [reg_idx_w-1:0]     o_rs1,
   output logic [reg_idx_w-1:0]     o_rs2,
   output logic [reg_idx_w-1:0]     o_rd,
   output alu_op_t                  o_alu_op,
   output alu_s1_sel_t              o_alu_s1_sel,
   output alu_s2_sel_t              o_alu_s2_sel,
   output exec_stage_t              o_next_stage,
   output logic                     o_wb_from_alu,
   output logic                     o_wb_from_imm,
   output logic                     o_next_pc_from_alu,
   output logic                     o_write_reg,
   output reg_in_sel_t              o_reg_in_sel,
   output logic [2:0]               o_funct3,
   output logic [branch_mask_w-1:0] o_branch_mask
);

   opcode_t    opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       full_len;   // low bits 11, everything else traps
   logic       is_op;
   logic       is_opimm;
   logic       sub_sel;
   logic       sra_sel;

   assign opcode   = i_instr[6:2];
   assign funct3   = i_instr[14:12];
   assign funct7   = i_instr[31:25];
   assign full_len = (i_instr[1:0] == len_32bit);
   assign is_op    = full_len && (opcode == op_op);
   assign is_opimm = full_len && (opcode == op_opimm);

   // addi has no subtract form, srai flags itself with funct7[5] only
   assign sub_sel = is_op && (funct7 == funct7_alt);
   assign sra_sel = is_op ? (funct7 == funct7_alt) : funct7[5];

   // register indices straight off the word so the regfile reads during decode
   assign o_rs1    = i_instr[19:15];
   assign o_rs2    = i_instr[24:20];
   assign o_rd     = i_instr[11:7];
   assign o_funct3 = funct3;

   // ALU operation
   always_comb begin
      o_alu_op = alu_add;  // address calc and everything else
      if (is_op && (funct7 == funct7_muldiv)) begin
         case (funct3)
            f3_add_sub: o_alu_op = alu_mul;
            f3_sll:     o_alu_op = alu_mulh;
            f3_slt:     o_alu_op = alu_mulhsu;
            f3_sltu:    o_alu_op = alu_mulhu;
            f3_xor:     o_alu_op = alu_div;
            f3_srl_sra: o_alu_op = alu_divu;
            f3_or:      o_alu_op = alu_rem;
            default:    o_alu_op = alu_remu;   // f3_and slot
         endcase
      end else if (is_op || is_opimm) begin
         case (funct3)
            f3_add_sub: o_alu_op = sub_sel ? alu_sub : alu_add;
            f3_sll:     o_alu_op = alu_sll;
            f3_slt:     o_alu_op = alu_slt;
            f3_sltu:    o_alu_op = alu_sltu;
            f3_xor:     o_alu_op = alu_xor;
            f3_srl_sra: o_alu_op = sra_sel ? alu_sra : alu_srl;
            f3_or:      o_alu_op = alu_or;
            default:    o_alu_op = alu_and;
         endcase
      end
   end

   // operand selects, writeback and next stage
   always_comb begin
      o_alu_s1_sel       = s1_reg1;
      o_alu_s2_sel       = s2_reg2;
      o_wb_from_alu      = 1'b0;
      o_wb_from_imm      = 1'b0;
      o_next_pc_from_alu = 1'b0;
      o_write_reg        = 1'b0;
      o_reg_in_sel       = reg_in_none;
      o_next_stage       = to_trap;   // unknown opcode or short word
      if (full_len) begin
         case (opcode)
            op_op: begin
               o_wb_from_alu = 1'b1;  // writeback happens in fetch
               o_next_stage  = to_fetch;
            end
            op_opimm: begin
               o_alu_s2_sel  = s2_imm;
               o_wb_from_alu = 1'b1;
               o_next_stage  = to_fetch;
            end
            op_load, op_store: begin
               o_alu_s2_sel = s2_imm;  // base + offset
               o_next_stage = (opcode == op_load) ? to_load : to_store;
            end
            op_jal, op_jalr: begin
               o_write_reg        = 1'b1;  // link address
               o_reg_in_sel       = reg_in_alu;
               o_alu_s1_sel       = (opcode == op_jal) ? s1_pc : s1_reg1;
               o_alu_s2_sel       = s2_imm;
               o_next_pc_from_alu = 1'b1;  // target from ALU sum
               o_next_stage       = to_fetch;
            end
            op_branch: begin
               o_next_stage = to_branch;  // compare on reg1 and reg2
            end
            op_auipc: begin
               o_alu_s1_sel  = s1_pc;
               o_alu_s2_sel  = s2_imm;
               o_wb_from_alu = 1'b1;
               o_next_stage  = to_fetch;
            end
            op_lui: begin
               o_wb_from_imm = 1'b1;  // ALU not needed
               o_reg_in_sel  = reg_in_imm;
               o_next_stage  = to_fetch;
            end
            op_miscmem: o_next_stage = to_fetch;  // fence as nop
            op_system:  o_next_stage = to_system;
            default:    o_next_stage = to_trap;
         endcase
      end
   end

   // one condition per branch funct3, only for real branches
   always_comb begin
      o_branch_mask = '0;
      if (full_len && (opcode == op_branch)) begin
         case (funct3)
            f3_beq:  o_branch_mask[br_eq]  = 1'b1;
            f3_bne:  o_branch_mask[br_ne]  = 1'b1;
            f3_blt:  o_branch_mask[br_lt]  = 1'b1;
            f3_bge:  o_branch_mask[br_ge]  = 1'b1;
            f3_bltu: o_branch_mask[br_ltu] = 1'b1;
            f3_bgeu: o_branch_mask[br_geu] = 1'b1;
            default: o_branch_mask = '0;  // 010, 011 undefined
         endcase
      end
   end

   // writeback source must be unique, the stage register relies on it
   a_wb_unique: assert property (@(i_instr) !(o_wb_from_alu && o_wb_from_imm))
      else $error("both writeback sources selected");

   // at most one branch condition
   a_mask_onehot: assert property (@(i_instr) $onehot0(o_branch_mask))
      else $error("branch mask not one-hot: %b", o_branch_mask);

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
   import rv_decode_pkg::*;
(
   input  logic                     i_clk,
   input  logic                     i_reset,
   input  logic                     i_en,
   input  logic [xlen-1:0]          i_imm,
   input  logic [reg_idx_w-1:0]     i_rd,
   input  alu_op_t                  i_alu_op,
   input  alu_s1_sel_t              i_alu_s1_sel,
   input  alu_s2_sel_t              i_alu_s2_sel,
   input  exec_stage_t              i_next_stage,
   input  logic                     i_wb_from_alu,
   input  logic                     i_wb_from_imm,
   input  logic                     i_next_pc_from_alu,
   input  logic                     i_write_reg,
   input  reg_in_sel_t              i_reg_in_sel,
   input  logic [2:0]               i_funct3,
   input  logic [branch_mask_w-1:0] i_branch_mask,
   output logic [xlen-1:0]          o_imm,
   output logic [reg_idx_w-1:0]     o_rd,
   output alu_op_t                  o_alu_op,
   output alu_s1_sel_t              o_alu_s1_sel,
   output alu_s2_sel_t              o_alu_s2_sel,
   output exec_stage_t              o_next_stage,
   output logic                     o_wb_from_alu,
   output logic                     o_wb_from_imm,
   output logic                     o_next_pc_from_alu,
   output logic                     o_write_reg,
   output reg_in_sel_t              o_reg_in_sel,
   output logic [2:0]               o_funct3,
   output logic [branch_mask_w-1:0] o_branch_mask,
   output logic                     o_valid
);

   // action flags, branch mask and immediate come out of reset cleared
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_valid            <= 1'b0;
         o_write_reg        <= 1'b0;
         o_wb_from_alu      <= 1'b0;
         o_wb_from_imm      <= 1'b0;
         o_next_pc_from_alu <= 1'b0;
         o_branch_mask      <= '0;
         o_imm              <= '0;
      end else begin
         o_valid <= i_en;  // single cycle pulse per captured word
         if (i_en) begin
            o_write_reg        <= i_write_reg;
            o_wb_from_alu      <= i_wb_from_alu;
            o_wb_from_imm      <= i_wb_from_imm;
            o_next_pc_from_alu <= i_next_pc_from_alu;
            o_branch_mask      <= i_branch_mask;
            o_imm              <= i_imm;
         end
      end
   end

   // selects and operation, held while i_en is low
   always_ff @(posedge i_clk) begin
      if (i_en) begin
         o_rd         <= i_rd;
         o_alu_op     <= i_alu_op;
         o_alu_s1_sel <= i_alu_s1_sel;
         o_alu_s2_sel <= i_alu_s2_sel;
         o_next_stage <= i_next_stage;
         o_reg_in_sel <= i_reg_in_sel;
         o_funct3     <= i_funct3;
      end
   end

   // no stale pulse leaks out right after reset
   a_no_valid_after_reset: assert property (@(posedge i_clk) i_reset |=> !o_valid)
      else $error("o_valid high in the cycle after reset");

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen
   import rv_decode_pkg::*;
(
   input  logic [xlen-1:0] i_instr,
   output logic [xlen-1:0] o_imm
);

   opcode_t opcode;
   logic    sign;   // immediate sign, always instr[31]
   logic    full_len;

   assign opcode   = i_instr[6:2];
   assign sign     = i_instr[xlen-1];
   assign full_len = (i_instr[1:0] == len_32bit);

   // format follows the opcode, R-type falls into I and is ignored downstream
   always_comb begin
      if (!full_len) begin
         o_imm = '0;  // no compressed support, trap path sees zero
      end else begin
         case (opcode)
            op_store: begin
               // S: imm[11:5] from funct7 slot, imm[4:0] from rd slot
               o_imm = {{(xlen-12){sign}}, i_instr[31:25], i_instr[11:7]};
            end
            op_branch: begin
               // B: halfword offset, bit 0 always zero
               o_imm = {{(xlen-13){sign}},
                        i_instr[31],      // imm[12]
                        i_instr[7],       // imm[11]
                        i_instr[30:25],   // imm[10:5]
                        i_instr[11:8],    // imm[4:1]
                        1'b0};
            end
            op_lui, op_auipc: begin
               o_imm = {i_instr[31:12], 12'b0};  // U: upper 20 bits
            end
            op_jal: begin
               // J: 21 bit signed offset
               o_imm = {{(xlen-21){sign}},
                        i_instr[31],      // imm[20]
                        i_instr[19:12],   // imm[19:12]
                        i_instr[20],      // imm[11]
                        i_instr[30:21],   // imm[10:1]
                        1'b0};
            end
            default: begin
               // I: loads, jalr, op-imm, system
               o_imm = {{(xlen-12){sign}}, i_instr[31:20]};
            end
         endcase
      end
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv \
   --top-module tb_rv_decoder \
   --Mdir obj_dir -o sim_tb_rv_decoder \
   -f all.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/sim_tb_rv_decoder 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASSED"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== rv_decode_pkg.sv ====
package rv_decode_pkg;

   localparam int xlen          = 32;  // data and instruction width
   localparam int reg_idx_w     = 5;   // x0..x31
   localparam int branch_mask_w = 6;   // eq ne lt ge ltu geu

   // low two bits of every full size instruction
   localparam logic [1:0] len_32bit = 2'b11;

   // major opcode, instr[6:2]
   typedef logic [4:0] opcode_t;

   localparam opcode_t op_load    = 5'b00000;
   localparam opcode_t op_miscmem = 5'b00011;  // fence, treated as nop
   localparam opcode_t op_opimm   = 5'b00100;
   localparam opcode_t op_auipc   = 5'b00101;
   localparam opcode_t op_store   = 5'b01000;
   localparam opcode_t op_op      = 5'b01100;  // reg-reg, also M extension
   localparam opcode_t op_lui     = 5'b01101;
   localparam opcode_t op_branch  = 5'b11000;
   localparam opcode_t op_jalr    = 5'b11001;
   localparam opcode_t op_jal     = 5'b11011;
   localparam opcode_t op_system  = 5'b11100;

   // funct3 for OP and OP-IMM, the M ops reuse the same slots
   localparam logic [2:0] f3_add_sub = 3'b000;  // mul
   localparam logic [2:0] f3_sll     = 3'b001;  // mulh
   localparam logic [2:0] f3_slt     = 3'b010;  // mulhsu
   localparam logic [2:0] f3_sltu    = 3'b011;  // mulhu
   localparam logic [2:0] f3_xor     = 3'b100;  // div
   localparam logic [2:0] f3_srl_sra = 3'b101;  // divu
   localparam logic [2:0] f3_or      = 3'b110;  // rem
   localparam logic [2:0] f3_and     = 3'b111;  // remu

   // funct3 for BRANCH, 010 and 011 are undefined
   localparam logic [2:0] f3_beq  = 3'b000;
   localparam logic [2:0] f3_bne  = 3'b001;
   localparam logic [2:0] f3_blt  = 3'b100;
   localparam logic [2:0] f3_bge  = 3'b101;
   localparam logic [2:0] f3_bltu = 3'b110;
   localparam logic [2:0] f3_bgeu = 3'b111;

   localparam logic [6:0] funct7_alt    = 7'b0100000;  // sub, sra
   localparam logic [6:0] funct7_muldiv = 7'b0000001;  // M extension

   // ALU operation
   typedef logic [4:0] alu_op_t;

   localparam alu_op_t alu_add    = 5'd0;
   localparam alu_op_t alu_sub    = 5'd1;
   localparam alu_op_t alu_sll    = 5'd2;
   localparam alu_op_t alu_slt    = 5'd3;
   localparam alu_op_t alu_sltu   = 5'd4;
   localparam alu_op_t alu_xor    = 5'd5;
   localparam alu_op_t alu_srl    = 5'd6;
   localparam alu_op_t alu_sra    = 5'd7;
   localparam alu_op_t alu_or     = 5'd8;
   localparam alu_op_t alu_and    = 5'd9;
   localparam alu_op_t alu_mul    = 5'd10;
   localparam alu_op_t alu_mulh   = 5'd11;
   localparam alu_op_t alu_mulhsu = 5'd12;
   localparam alu_op_t alu_mulhu  = 5'd13;
   localparam alu_op_t alu_div    = 5'd14;
   localparam alu_op_t alu_divu   = 5'd15;
   localparam alu_op_t alu_rem    = 5'd16;
   localparam alu_op_t alu_remu   = 5'd17;

   // ALU operand muxes
   typedef logic       alu_s1_sel_t;
   typedef logic [1:0] alu_s2_sel_t;

   localparam alu_s1_sel_t s1_reg1 = 1'b0;
   localparam alu_s1_sel_t s1_pc   = 1'b1;
   localparam alu_s2_sel_t s2_reg2 = 2'd0;
   localparam alu_s2_sel_t s2_imm  = 2'd1;

   // register file input mux
   typedef logic [1:0] reg_in_sel_t;

   localparam reg_in_sel_t reg_in_none = 2'd0;
   localparam reg_in_sel_t reg_in_alu  = 2'd1;
   localparam reg_in_sel_t reg_in_imm  = 2'd2;

   // where execute goes after this instruction
   typedef logic [2:0] exec_stage_t;

   localparam exec_stage_t to_fetch  = 3'd0;
   localparam exec_stage_t to_load   = 3'd1;
   localparam exec_stage_t to_store  = 3'd2;
   localparam exec_stage_t to_branch = 3'd3;
   localparam exec_stage_t to_system = 3'd4;
   localparam exec_stage_t to_trap   = 3'd5;

   // bit positions in the branch mask
   localparam int br_eq  = 0;
   localparam int br_ne  = 1;
   localparam int br_lt  = 2;
   localparam int br_ge  = 3;
   localparam int br_ltu = 4;
   localparam int br_geu = 5;

endpackage

// ==== rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder
   import rv_decode_pkg::*;
(
   input  logic                     i_clk,
   input  logic                     i_reset,
   input  logic                     i_en,
   input  logic [xlen-1:0]          i_instr,
   output logic [reg_idx_w-1:0]     o_rs1,   // combinational, regfile read port
   output logic [reg_idx_w-1:0]     o_rs2,
   output logic [reg_idx_w-1:0]     o_rd,
   output logic [xlen-1:0]          o_imm,
   output logic [branch_mask_w-1:0] o_branch_mask,
   output alu_op_t                  o_alu_op,
   output alu_s1_sel_t              o_alu_s1_sel,
   output alu_s2_sel_t              o_alu_s2_sel,
   output exec_stage_t              o_next_stage,
   output logic                     o_wb_from_alu,
   output logic                     o_wb_from_imm,
   output logic                     o_next_pc_from_alu,
   output reg_in_sel_t              o_reg_in_sel,
   output logic [2:0]               o_funct3,
   output logic                     o_write_reg,
   output logic                     o_valid
);

   // decode results before the stage register
   logic [xlen-1:0]          imm;
   logic [reg_idx_w-1:0]     rd;
   alu_op_t                  alu_op;
   alu_s1_sel_t              alu_s1_sel;
   alu_s2_sel_t              alu_s2_sel;
   exec_stage_t              next_stage;
   logic                     wb_from_alu;
   logic                     wb_from_imm;
   logic                     next_pc_from_alu;
   logic                     write_reg;
   reg_in_sel_t              reg_in_sel;
   logic [2:0]               funct3;
   logic [branch_mask_w-1:0] branch_mask;

   imm_gen u_imm_gen (
      .i_instr (i_instr),
      .o_imm   (imm)
   );

   ctrl_decode u_ctrl_decode (
      .i_instr            (i_instr),
      .o_rs1              (o_rs1),   // bypass the stage register
      .o_rs2              (o_rs2),
      .o_rd               (rd),
      .o_alu_op           (alu_op),
      .o_alu_s1_sel       (alu_s1_sel),
      .o_alu_s2_sel       (alu_s2_sel),
      .o_next_stage       (next_stage),
      .o_wb_from_alu      (wb_from_alu),
      .o_wb_from_imm      (wb_from_imm),
      .o_next_pc_from_alu (next_pc_from_alu),
      .o_write_reg        (write_reg),
      .o_reg_in_sel       (reg_in_sel),
      .o_funct3           (funct3),
      .o_branch_mask      (branch_mask)
   );

   decode_stage u_decode_stage (
      .i_clk              (i_clk),
      .i_reset            (i_reset),
      .i_en               (i_en),
      .i_imm              (imm),
      .i_rd               (rd),
      .i_alu_op           (alu_op),
      .i_alu_s1_sel       (alu_s1_sel),
      .i_alu_s2_sel       (alu_s2_sel),
      .i_next_stage       (next_stage),
      .i_wb_from_alu      (wb_from_alu),
      .i_wb_from_imm      (wb_from_imm),
      .i_next_pc_from_alu (next_pc_from_alu),
      .i_write_reg        (write_reg),
      .i_reg_in_sel       (reg_in_sel),
      .i_funct3           (funct3),
      .i_branch_mask      (branch_mask),
      .o_imm              (o_imm),
      .o_rd               (o_rd),
      .o_alu_op           (o_alu_op),
      .o_alu_s1_sel       (o_alu_s1_sel),
      .o_alu_s2_sel       (o_alu_s2_sel),
      .o_next_stage       (o_next_stage),
      .o_wb_from_alu      (o_wb_from_alu),
      .o_wb_from_imm      (o_wb_from_imm),
      .o_next_pc_from_alu (o_next_pc_from_alu),
      .o_write_reg        (o_write_reg),
      .o_reg_in_sel       (o_reg_in_sel),
      .o_funct3           (o_funct3),
      .o_branch_mask      (o_branch_mask),
      .o_valid            (o_valid)
   );

endmodule

// ==== tb_rv_decoder.sv ====
`timescale 1ns/1ps

module tb_rv_decoder
   import rv_decode_pkg::*;
();

   localparam int valid_timeout = 8;   // cycles to wait for o_valid

   logic                     i_clk;
   logic                     i_reset;
   logic                     i_en;
   logic [xlen-1:0]          i_instr;
   logic [reg_idx_w-1:0]     o_rs1;
   logic [reg_idx_w-1:0]     o_rs2;
   logic [reg_idx_w-1:0]     o_rd;
   logic [xlen-1:0]          o_imm;
   logic [branch_mask_w-1:0] o_branch_mask;
   alu_op_t                  o_alu_op;
   alu_s1_sel_t              o_alu_s1_sel;
   alu_s2_sel_t              o_alu_s2_sel;
   exec_stage_t              o_next_stage;
   logic                     o_wb_from_alu;
   logic                     o_wb_from_imm;
   logic                     o_next_pc_from_alu;
   reg_in_sel_t              o_reg_in_sel;
   logic [2:0]               o_funct3;
   logic                     o_write_reg;
   logic                     o_valid;

   logic [31:0] lcg_state;   // random field source

   rv_decoder dut (
      .i_clk              (i_clk),
      .i_reset            (i_reset),
      .i_en               (i_en),
      .i_instr            (i_instr),
      .o_rs1              (o_rs1),
      .o_rs2              (o_rs2),
      .o_rd               (o_rd),
      .o_imm              (o_imm),
      .o_branch_mask      (o_branch_mask),
      .o_alu_op           (o_alu_op),
      .o_alu_s1_sel       (o_alu_s1_sel),
      .o_alu_s2_sel       (o_alu_s2_sel),
      .o_next_stage       (o_next_stage),
      .o_wb_from_alu      (o_wb_from_alu),
      .o_wb_from_imm      (o_wb_from_imm),
      .o_next_pc_from_alu (o_next_pc_from_alu),
      .o_reg_in_sel       (o_reg_in_sel),
      .o_funct3           (o_funct3),
      .o_write_reg        (o_write_reg),
      .o_valid            (o_valid)
   );

   initial begin
      i_clk = 1'b0;
      forever #4 i_clk = ~i_clk;   // 8 ns period
   end

   // 32 bit LCG step with the ANSI C constants
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic logic [31:0] build_r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd, input opcode_t opc);
      return {f7, rs2, rs1, f3, rd, opc, 2'b11};
   endfunction

   function automatic logic [31:0] build_i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input opcode_t opc);
      return {imm, rs1, f3, rd, opc, 2'b11};
   endfunction

   task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
      if (act !== exp) begin
         $display("error: time %0t, %s = 0x%0h, expected 0x%0h", $time, name, act, exp);
         $display("TEST FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // starts and ends on a falling edge with o_valid high at the end
   task automatic issue_and_wait(input logic [31:0] instr);
      int cycles;
      i_instr = instr;
      i_en    = 1'b1;
      #1;   // regfile indices are combinational
      check("o_rs1", 32'(o_rs1), 32'(instr[19:15]));
      check("o_rs2", 32'(o_rs2), 32'(instr[24:20]));
      @(negedge i_clk);
      i_en   = 1'b0;
      cycles = 1;
      while (!o_valid && (cycles < valid_timeout)) begin
         @(negedge i_clk);
         cycles++;
      end
      if (!o_valid) begin
         $display("timeout: o_valid never rose after instruction 0x%h", instr);
         $display("TEST FAILED");
         $fatal(1, "no valid pulse");
      end else begin
         check("valid latency", cycles, 1);   // exactly one stage
         check("o_rd", 32'(o_rd), 32'(instr[11:7]));
         check("o_funct3", 32'(o_funct3), 32'(instr[14:12]));
      end
   endtask

   task automatic check_controls(input alu_op_t alu, input alu_s1_sel_t s1,
                                 input alu_s2_sel_t s2, input exec_stage_t stage,
                                 input logic wb_alu, input logic wb_imm, input logic npc,
                                 input logic wr, input reg_in_sel_t rin,
                                 input logic [branch_mask_w-1:0] mask);
      check("o_alu_op", 32'(o_alu_op), 32'(alu));
      check("o_alu_s1_sel", 32'(o_alu_s1_sel), 32'(s1));
      check("o_alu_s2_sel", 32'(o_alu_s2_sel), 32'(s2));
      check("o_next_stage", 32'(o_next_stage), 32'(stage));
      check("o_wb_from_alu", 32'(o_wb_from_alu), 32'(wb_alu));
      check("o_wb_from_imm", 32'(o_wb_from_imm), 32'(wb_imm));
      check("o_next_pc_from_alu", 32'(o_next_pc_from_alu), 32'(npc));
      check("o_write_reg", 32'(o_write_reg), 32'(wr));
      check("o_reg_in_sel", 32'(o_reg_in_sel), 32'(rin));
      check("o_branch_mask", 32'(o_branch_mask), 32'(mask));
   endtask

   task automatic test_reset();
      int i;
      check("o_valid", 32'(o_valid), 32'd0);
      check("o_write_reg", 32'(o_write_reg), 32'd0);
      check("o_wb_from_alu", 32'(o_wb_from_alu), 32'd0);
      check("o_wb_from_imm", 32'(o_wb_from_imm), 32'd0);
      check("o_next_pc_from_alu", 32'(o_next_pc_from_alu), 32'd0);
      check("o_branch_mask", 32'(o_branch_mask), 32'd0);
      check("o_imm", o_imm, 32'd0);
      for (i = 0; i < 4; i++) begin
         i_instr = next_rand();   // bus noise while enable stays low
         @(negedge i_clk);
         check("o_valid", 32'(o_valid), 32'd0);
      end
      check("o_imm", o_imm, 32'd0);   // nothing captured
   endtask

   task automatic test_alu_ops();
      alu_op_t     base_ops[8];
      alu_op_t     m_ops[8];
      logic [31:0] r;
      logic [11:0] imm;
      logic [3:0]  f3;
      base_ops = '{alu_add, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_or, alu_and};
      m_ops    = '{alu_mul, alu_mulh, alu_mulhsu, alu_mulhu, alu_div, alu_divu, alu_rem, alu_remu};
      for (f3 = 4'd0; f3 < 4'd8; f3++) begin
         r = next_rand();
         issue_and_wait(build_r_word(7'b0, r[24:20], r[19:15], f3[2:0], r[11:7], op_op));
         check_controls(base_ops[f3[2:0]], s1_reg1, s2_reg2, to_fetch,
                        1'b1, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
         issue_and_wait(build_r_word(funct7_muldiv, r[29:25], r[14:10], f3[2:0], r[6:2], op_op));
         check_controls(m_ops[f3[2:0]], s1_reg1, s2_reg2, to_fetch,
                        1'b1, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
         // shifts keep the upper immediate slot clear
         imm = (f3 == 4'd1 || f3 == 4'd5) ? {7'b0, r[24:20]} : r[31:20];
         issue_and_wait(build_i_word(imm, r[19:15], f3[2:0], r[11:7], op_opimm));
         check_controls(base_ops[f3[2:0]], s1_reg1, s2_imm, to_fetch,
                        1'b1, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
         check("o_imm", o_imm, {{20{imm[11]}}, imm});
      end
      r = next_rand();
      issue_and_wait(build_r_word(funct7_alt, r[24:20], r[19:15], 3'b000, r[11:7], op_op));
      check_controls(alu_sub, s1_reg1, s2_reg2, to_fetch, 1'b1, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
      issue_and_wait(build_r_word(funct7_alt, r[24:20], r[19:15], 3'b101, r[11:7], op_op));
      check_controls(alu_sra, s1_reg1, s2_reg2, to_fetch, 1'b1, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
      issue_and_wait(build_i_word({funct7_alt, r[24:20]}, r[19:15], 3'b101, r[11:7], op_opimm));
      check_controls(alu_sra, s1_reg1, s2_imm, to_fetch, 1'b1, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
   endtask

   // random offsets encoded per format and expected back sign extended
   task automatic test_immediates();
      int          n;
      logic [31:0] r;
      logic [11:0] imm12;
      logic [12:0] imm13;
      logic [19:0] imm20;
      logic [20:0] imm21;
      for (n = 0; n < 10; n++) begin
         r = next_rand();
         imm12 = r[31:20];
         issue_and_wait({imm12, r[19:15], 3'b010, r[11:7], op_load, 2'b11});
         check("o_imm I", o_imm, {{20{imm12[11]}}, imm12});
         r = next_rand();
         imm12 = r[27:16];
         issue_and_wait({imm12[11:5], r[24:20], r[19:15], 3'b010, imm12[4:0], op_store, 2'b11});
         check("o_imm S", o_imm, {{20{imm12[11]}}, imm12});
         r = next_rand();
         imm13 = {r[30:19], 1'b0};   // halfword aligned
         issue_and_wait({imm13[12], imm13[10:5], r[24:20], r[19:15], 3'b000,
                         imm13[4:1], imm13[11], op_branch, 2'b11});
         check("o_imm B", o_imm, {{19{imm13[12]}}, imm13});
         r = next_rand();
         imm20 = r[31:12];
         issue_and_wait({imm20, r[11:7], (n[0] ? op_lui : op_auipc), 2'b11});
         check("o_imm U", o_imm, {imm20, 12'h000});
         r = next_rand();
         imm21 = {r[31:12], 1'b0};
         issue_and_wait({imm21[20], imm21[10:1], imm21[11], imm21[19:12], r[11:7], op_jal, 2'b11});
         check("o_imm J", o_imm, {{11{imm21[20]}}, imm21});
      end
   endtask

   task automatic test_branches();
      logic [2:0]  f3_list[6];
      logic [31:0] r;
      int          i;
      f3_list = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};   // eq ne lt ge ltu geu
      for (i = 0; i < 6; i++) begin
         r = next_rand();
         issue_and_wait({r[31:25], r[24:20], r[19:15], f3_list[i], r[11:7], op_branch, 2'b11});
         check_controls(alu_add, s1_reg1, s2_reg2, to_branch,
                        1'b0, 1'b0, 1'b0, 1'b0, reg_in_none, 6'b1 << i);
      end
      r = next_rand();
      issue_and_wait({r[31:25], r[24:20], r[19:15], 3'b010, r[11:7], op_branch, 2'b11});
      check_controls(alu_add, s1_reg1, s2_reg2, to_branch, 1'b0, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
      issue_and_wait({r[31:25], r[24:20], r[19:15], 3'b011, r[11:7], op_branch, 2'b11});
      check_controls(alu_add, s1_reg1, s2_reg2, to_branch, 1'b0, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
      issue_and_wait(build_i_word(r[31:20], r[19:15], 3'b001, r[11:7], op_opimm));
      check("o_branch_mask", 32'(o_branch_mask), 32'd0);   // bne funct3 on a non-branch
   endtask

   task automatic test_other_opcodes();
      logic [31:0] r;
      logic [31:0] w;
      r = next_rand();
      issue_and_wait(build_i_word(r[31:20], r[19:15], 3'b010, r[11:7], op_load));
      check_controls(alu_add, s1_reg1, s2_imm, to_load, 1'b0, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
      issue_and_wait({r[31:25], r[24:20], r[19:15], 3'b010, r[11:7], op_store, 2'b11});
      check_controls(alu_add, s1_reg1, s2_imm, to_store, 1'b0, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
      issue_and_wait({r[31:12], r[11:7], op_jal, 2'b11});
      check_controls(alu_add, s1_pc, s2_imm, to_fetch, 1'b0, 1'b0, 1'b1, 1'b1, reg_in_alu, '0);
      issue_and_wait(build_i_word(r[31:20], r[19:15], 3'b000, r[11:7], op_jalr));
      check_controls(alu_add, s1_reg1, s2_imm, to_fetch, 1'b0, 1'b0, 1'b1, 1'b1, reg_in_alu, '0);
      issue_and_wait({r[31:12], r[11:7], op_auipc, 2'b11});
      check_controls(alu_add, s1_pc, s2_imm, to_fetch, 1'b1, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
      issue_and_wait({r[31:12], r[11:7], op_lui, 2'b11});
      check_controls(alu_add, s1_reg1, s2_reg2, to_fetch, 1'b0, 1'b1, 1'b0, 1'b0, reg_in_imm, '0);
      issue_and_wait(build_i_word(12'h0ff, 5'd0, 3'b000, 5'd0, op_miscmem));   // fence
      check_controls(alu_add, s1_reg1, s2_reg2, to_fetch, 1'b0, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
      issue_and_wait(build_i_word(12'h000, 5'd0, 3'b000, 5'd0, op_system));    // ecall
      check_controls(alu_add, s1_reg1, s2_reg2, to_system, 1'b0, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
      issue_and_wait(build_r_word(7'b0, r[24:20], r[19:15], 3'b000, r[11:7], 5'b11111));
      check_controls(alu_add, s1_reg1, s2_reg2, to_trap, 1'b0, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
      issue_and_wait(build_r_word(7'b0, r[24:20], r[19:15], 3'b000, r[11:7], 5'b00010));
      check_controls(alu_add, s1_reg1, s2_reg2, to_trap, 1'b0, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
      w = build_r_word(funct7_alt, r[24:20], r[19:15], 3'b000, r[11:7], op_op);
      w[1:0] = 2'b10;   // compressed encoding is not supported
      issue_and_wait(w);
      check_controls(alu_add, s1_reg1, s2_reg2, to_trap, 1'b0, 1'b0, 1'b0, 1'b0, reg_in_none, '0);
      check("o_imm", o_imm, 32'd0);
   endtask

   // back to back enables then a gap in i_en
   task automatic test_timing();
      logic [31:0] w[3];
      logic [4:0]  exp_rd[3];
      alu_op_t     exp_op[3];
      exec_stage_t exp_stage[3];
      logic [31:0] exp_imm[3];
      int          k;
      w[0]      = build_r_word(funct7_alt, 5'd3, 5'd2, 3'b000, 5'd1, op_op);   // sub x1
      w[1]      = {20'habcde, 5'd4, op_lui, 2'b11};
      w[2]      = build_r_word(7'b0, 5'd6, 5'd5, 3'b101, 5'd8, op_branch);      // bge with offset 8
      exp_rd    = '{5'd1, 5'd4, 5'd8};
      exp_op    = '{alu_sub, alu_add, alu_add};
      exp_stage = '{to_fetch, to_fetch, to_branch};
      exp_imm   = '{32'h0000_0403, 32'habcd_e000, 32'h0000_0008};
      i_instr = w[0];
      i_en    = 1'b1;
      for (k = 0; k < 3; k++) begin
         @(negedge i_clk);
         if (k < 2) begin
            i_instr = w[k+1];
         end else begin
            i_en = 1'b0;
         end
         check("o_valid", 32'(o_valid), 32'd1);
         check("o_rd", 32'(o_rd), 32'(exp_rd[k]));
         check("o_alu_op", 32'(o_alu_op), 32'(exp_op[k]));
         check("o_next_stage", 32'(o_next_stage), 32'(exp_stage[k]));
         check("o_imm", o_imm, exp_imm[k]);
      end
      i_instr = w[1];   // must not leak through while idle
      repeat (2) begin
         @(negedge i_clk);
         check("o_valid", 32'(o_valid), 32'd0);
         check("o_rd", 32'(o_rd), 32'd8);
         check("o_next_stage", 32'(o_next_stage), 32'(to_branch));
         check("o_imm", o_imm, 32'h0000_0008);
      end
   endtask

   initial begin
      lcg_state = 32'd45;
      i_reset   = 1'b1;
      i_en      = 1'b0;
      i_instr   = '0;
      repeat (3) @(posedge i_clk);
      @(negedge i_clk);
      i_reset = 1'b0;
      test_reset();
      test_alu_ops();
      test_immediates();
      test_branches();
      test_other_opcodes();
      test_timing();
      $display("TEST PASSED");
      $finish;
   end

endmodule
